/* Makefile */
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

$(OBJ)/Vtb_bridge: vlog.f $(shell cat vlog.f)
	verilator --binary --timing --assert --top-module tb_bridge \
	  -Mdir $(OBJ) -o Vtb_bridge -f vlog.f

test: $(OBJ)/Vtb_bridge
	@out="$$(./$(OBJ)/Vtb_bridge)"; echo "$$out"; \
	  echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ)

/* rtl/axi_pkg.sv */
// --------------------
// AXI3 write channel widths, burst and response codes,
// and the address-queue entry type.
// --------------------
`default_nettype none

package axi_pkg;

  localparam int AXI_ID_W    = 4;
  localparam int AXI_ADDR_W  = 32;
  localparam int AXI_DATA_W  = 32;
  localparam int AXI_STRB_W  = 4;
  // Burst length is coded as the number of beats minus one.
  localparam int AXI_LEN_W   = 4;
  localparam int AXI_SIZE_W  = 3;
  localparam int AXI_BURST_W = 2;
  localparam int AXI_RESP_W  = 2;

  // Sideband fields that the bridge accepts but ignores.
  localparam int AXI_LOCK_W  = 2;
  localparam int AXI_CACHE_W = 4;
  localparam int AXI_PROT_W  = 3;

  localparam logic [AXI_BURST_W-1:0] BURST_FIXED = 2'b00;
  localparam logic [AXI_BURST_W-1:0] BURST_INCR  = 2'b01;
  localparam logic [AXI_BURST_W-1:0] BURST_WRAP  = 2'b10;

  localparam logic [AXI_RESP_W-1:0] RESP_OKAY = 2'b00;

  // Four bytes per beat.
  localparam logic [AXI_SIZE_W-1:0] SIZE_WORD = 3'b010;

  // One entry per accepted burst.
  typedef struct packed {
    logic [AXI_BURST_W-1:0] burst;
    logic [AXI_ADDR_W-1:0]  addr;
    logic [AXI_LEN_W-1:0]   len;
  } aw_info_t;

endpackage

`default_nettype wire

/* rtl/axi_wb_write_bridge.sv */
// --------------------
// AXI3 to Wishbone write bridge top level.
// --------------------
`default_nettype none

module axi_wb_write_bridge import axi_pkg::*, bridge_pkg::*; (
  input  logic                   axi_clk,
  input  logic                   reset_n,

  input  logic [AXI_ID_W-1:0]    awid,
  input  logic [AXI_ADDR_W-1:0]  awaddr,
  input  logic [AXI_LEN_W-1:0]   awlen,
  input  logic [AXI_SIZE_W-1:0]  awsize,
  input  logic [AXI_BURST_W-1:0] awburst,
  input  logic [AXI_LOCK_W-1:0]  awlock,
  input  logic [AXI_CACHE_W-1:0] awcache,
  input  logic [AXI_PROT_W-1:0]  awprot,
  input  logic                   awvalid,
  output logic                   awready,

  input  logic [AXI_ID_W-1:0]    wid,
  input  logic [AXI_DATA_W-1:0]  wdata,
  input  logic [AXI_STRB_W-1:0]  wstrb,
  input  logic                   wlast,
  input  logic                   wvalid,
  output logic                   wready,

  output logic [AXI_ID_W-1:0]    bid,
  output logic [AXI_RESP_W-1:0]  bresp,
  output logic                   bvalid,
  input  logic                   bready,

  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [WB_ADR_W-1:0]    wb_adr,
  output logic [WB_DAT_W-1:0]    wb_dat_o,
  output logic [WB_SEL_W-1:0]    wb_sel,
  input  logic                   wb_ack
);

  // Lock, cache and protection attributes have no Wishbone counterpart.

  queue_if #(.payload_t(aw_info_t)) addr_q ();
  queue_if #(.payload_t(w_beat_t))  data_q ();

  axi_write_ingress ingress_i (
    .axi_clk (axi_clk),
    .reset_n (reset_n),
    .awid    (awid),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .awsize  (awsize),
    .awburst (awburst),
    .awvalid (awvalid),
    .awready (awready),
    .wid     (wid),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .wvalid  (wvalid),
    .wready  (wready),
    .bid     (bid),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .addr_q  (addr_q.producer),
    .data_q  (data_q.producer)
  );

  sync_fifo #(
    .payload_t (aw_info_t),
    .DEPTH     (ADDR_QUEUE_DEPTH)
  ) addr_fifo_i (
    .axi_clk (axi_clk),
    .reset_n (reset_n),
    .q       (addr_q.fifo)
  );

  sync_fifo #(
    .payload_t (w_beat_t),
    .DEPTH     (DATA_QUEUE_DEPTH)
  ) data_fifo_i (
    .axi_clk (axi_clk),
    .reset_n (reset_n),
    .q       (data_q.fifo)
  );

  wb_write_egress egress_i (
    .axi_clk  (axi_clk),
    .reset_n  (reset_n),
    .addr_q   (addr_q.consumer),
    .data_q   (data_q.consumer),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat_o),
    .wb_sel   (wb_sel),
    .wb_ack   (wb_ack)
  );

endmodule

`default_nettype wire

/* rtl/axi_write_ingress.sv */
// --------------------
// AXI3 write target. Fills the address and data queues
// and returns a posted B response per burst.
// --------------------
`default_nettype none

module axi_write_ingress import axi_pkg::*, bridge_pkg::*; (
  input  logic                   axi_clk,
  input  logic                   reset_n,

  input  logic [AXI_ID_W-1:0]    awid,
  input  logic [AXI_ADDR_W-1:0]  awaddr,
  input  logic [AXI_LEN_W-1:0]   awlen,
  input  logic [AXI_SIZE_W-1:0]  awsize,
  input  logic [AXI_BURST_W-1:0] awburst,
  input  logic                   awvalid,
  output logic                   awready,

  input  logic [AXI_ID_W-1:0]    wid,
  input  logic [AXI_DATA_W-1:0]  wdata,
  input  logic [AXI_STRB_W-1:0]  wstrb,
  input  logic                   wlast,
  input  logic                   wvalid,
  output logic                   wready,

  output logic [AXI_ID_W-1:0]    bid,
  output logic [AXI_RESP_W-1:0]  bresp,
  output logic                   bvalid,
  input  logic                   bready,

  queue_if.producer              addr_q,
  queue_if.producer              data_q
);

  typedef enum logic [1:0] {IDLE, WDATA, BRESP} state_t;

  state_t               state;
  state_t               next_state;
  logic                 aw_hs;
  logic                 w_hs;
  logic [AXI_ID_W-1:0]  last_wid;
  logic [AXI_ID_W-1:0]  burst_id;
  logic [AXI_LEN_W-1:0] burst_len;
  logic [AXI_LEN_W-1:0] beat_cnt;
  aw_info_t             aw_entry;
  w_beat_t              w_entry;

  assign awready = (state == IDLE) & ~addr_q.full;
  assign wready  = (state == WDATA) & ~data_q.full;

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;

  assign aw_entry = '{burst: awburst, addr: awaddr, len: awlen};
  assign w_entry  = '{data: wdata, strb: wstrb, last: wlast};

  assign addr_q.push      = aw_hs;
  assign addr_q.push_data = aw_entry;
  assign data_q.push      = w_hs;
  assign data_q.push_data = w_entry;

  // Writes are posted, so the response is always OKAY.
  assign bvalid = (state == BRESP);
  assign bresp  = RESP_OKAY;
  assign bid    = last_wid;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (aw_hs) begin
          next_state = WDATA;
        end
      end
      WDATA: begin
        if (w_hs && wlast) begin
          next_state = BRESP;
        end
      end
      BRESP: begin
        if (bready) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge axi_clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= IDLE;
      last_wid  <= '0;
      burst_id  <= '0;
      burst_len <= '0;
      beat_cnt  <= '0;
    end else begin
      state <= next_state;
      if (aw_hs) begin
        burst_id  <= awid;
        burst_len <= awlen;
        beat_cnt  <= '0;
      end
      if (w_hs) begin
        last_wid <= wid;
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  a_word_size: assert property (@(posedge axi_clk) disable iff (!reset_n)
    aw_hs |-> awsize == SIZE_WORD);

  a_no_wrap: assert property (@(posedge axi_clk) disable iff (!reset_n)
    aw_hs |-> awburst != BURST_WRAP);

  // WLAST must come with beat awlen+1 and on no other beat.
  a_wlast_position: assert property (@(posedge axi_clk) disable iff (!reset_n)
    w_hs |-> wlast == (beat_cnt == burst_len));

  // No interleaving, so every beat belongs to the open burst.
  a_wid_matches: assert property (@(posedge axi_clk) disable iff (!reset_n)
    w_hs |-> wid == burst_id);

endmodule

`default_nettype wire

/* rtl/bridge_pkg.sv */
// --------------------
// Wishbone widths, queue depths and the data-beat type.
// --------------------
`default_nettype none

package bridge_pkg;

  localparam int WB_ADR_W = 32;
  localparam int WB_DAT_W = 32;
  localparam int WB_SEL_W = 4;

  // Address step between beats of an INCR burst.
  localparam int BEAT_BYTES = 4;

  // The address queue only needs a few entries since the ingress
  // takes one burst at a time. The data queue holds one full burst.
  localparam int ADDR_QUEUE_DEPTH = 4;
  localparam int DATA_QUEUE_DEPTH = 16;

  // One entry per accepted W beat.
  typedef struct packed {
    logic [WB_DAT_W-1:0] data;
    logic [WB_SEL_W-1:0] strb;
    logic                last;
  } w_beat_t;

endpackage

`default_nettype wire

/* rtl/queue_if.sv */
// --------------------
// Push/pop queue interface.
// --------------------
`default_nettype none

interface queue_if #(
  parameter type payload_t = logic
) ();

  logic     push;
  payload_t push_data;
  logic     full;
  logic     pop;
  payload_t pop_data;
  logic     empty;

  modport producer (
    output push,
    output push_data,
    input  full
  );

  modport fifo (
    input  push,
    input  push_data,
    output full,
    input  pop,
    output pop_data,
    output empty
  );

  modport consumer (
    output pop,
    input  pop_data,
    input  empty
  );

endinterface

`default_nettype wire

/* rtl/sync_fifo.sv */
// --------------------
// Synchronous FIFO with a typed payload.
// --------------------
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic  axi_clk,
  input  logic  reset_n,
  queue_if.fifo q
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  // Pointers wrap explicitly, so DEPTH 1 works too.
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign q.full  = (count == (PTR_W + 1)'(DEPTH));
  assign q.empty = (count == '0);

  assign do_push = q.push & ~q.full;
  assign do_pop  = q.pop & ~q.empty;

  // The head entry is always visible.
  assign q.pop_data = mem[rd_ptr];

  always_ff @(posedge axi_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= q.push_data;
    end
  end

  always_ff @(posedge axi_clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The neighbors must respect full and empty.
  a_no_push_when_full: assert property (@(posedge axi_clk) disable iff (!reset_n)
    q.push |-> !q.full);

  a_no_pop_when_empty: assert property (@(posedge axi_clk) disable iff (!reset_n)
    q.pop |-> !q.empty);

endmodule

`default_nettype wire

/* rtl/wb_write_egress.sv */
// --------------------
// Wishbone classic master. Replays each queued burst
// as one block of single writes.
// --------------------
`default_nettype none

module wb_write_egress import axi_pkg::*, bridge_pkg::*; (
  input  logic                axi_clk,
  input  logic                reset_n,

  queue_if.consumer           addr_q,
  queue_if.consumer           data_q,

  output logic                wb_cyc,
  output logic                wb_stb,
  output logic                wb_we,
  output logic [WB_ADR_W-1:0] wb_adr,
  output logic [WB_DAT_W-1:0] wb_dat_o,
  output logic [WB_SEL_W-1:0] wb_sel,
  input  logic                wb_ack
);

  typedef enum logic [1:0] {IDLE, BEAT, NEXT} state_t;

  state_t               state;
  logic [WB_ADR_W-1:0]  cur_adr;
  logic [AXI_LEN_W-1:0] beats_left;
  logic                 fixed_burst;
  logic                 load;
  logic                 beat_done;
  aw_info_t             aw_head;
  w_beat_t              w_head;

  assign aw_head = addr_q.pop_data;
  assign w_head  = data_q.pop_data;

  assign load       = (state == IDLE) & ~addr_q.empty;
  assign addr_q.pop = load;

  // Cycle is held for the whole burst. Strobe waits for a beat in the queue,
  // and once up it stays up until ack since the queue cannot drain meanwhile.
  assign wb_cyc   = (state == BEAT);
  assign wb_stb   = (state == BEAT) & ~data_q.empty;
  assign wb_we    = wb_cyc;
  assign wb_adr   = cur_adr;
  assign wb_dat_o = w_head.data;
  assign wb_sel   = w_head.strb;

  assign beat_done  = wb_stb & wb_ack;
  assign data_q.pop = beat_done;

  always_ff @(posedge axi_clk or negedge reset_n) begin
    if (!reset_n) begin
      state       <= IDLE;
      cur_adr     <= '0;
      beats_left  <= '0;
      fixed_burst <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (load) begin
            cur_adr     <= aw_head.addr;
            beats_left  <= aw_head.len;
            fixed_burst <= (aw_head.burst == BURST_FIXED);
            state       <= BEAT;
          end
        end
        BEAT: begin
          if (beat_done) begin
            if (!fixed_burst) begin
              cur_adr <= cur_adr + WB_ADR_W'(BEAT_BYTES);
            end
            if (beats_left == '0) begin
              state <= NEXT;
            end else begin
              beats_left <= beats_left - 1'b1;
            end
          end
        end
        // One bus-idle cycle closes the block.
        NEXT: begin
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // The last flag packed by the ingress must line up with the burst length.
  a_last_matches_count: assert property (@(posedge axi_clk) disable iff (!reset_n)
    beat_done |-> w_head.last == (beats_left == '0));

endmodule

`default_nettype wire

/* testbench/tb_bridge.sv */
// --------------------
// Testbench for the AXI3 to Wishbone write bridge. Drives
// AXI bursts and checks the Wishbone writes and B responses.
// --------------------
`default_nettype none

module tb_bridge import axi_pkg::*, bridge_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED    = 32'h761b_e84e;
  localparam int          TIMEOUT = 500;

  typedef struct packed {
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
    logic [WB_SEL_W-1:0] sel;
    logic                first;
  } wb_write_t;

  logic                   axi_clk;
  logic                   reset_n;
  logic [AXI_ID_W-1:0]    awid;
  logic [AXI_ADDR_W-1:0]  awaddr;
  logic [AXI_LEN_W-1:0]   awlen;
  logic [AXI_SIZE_W-1:0]  awsize;
  logic [AXI_BURST_W-1:0] awburst;
  logic [AXI_LOCK_W-1:0]  awlock;
  logic [AXI_CACHE_W-1:0] awcache;
  logic [AXI_PROT_W-1:0]  awprot;
  logic                   awvalid;
  logic                   awready;
  logic [AXI_ID_W-1:0]    wid;
  logic [AXI_DATA_W-1:0]  wdata;
  logic [AXI_STRB_W-1:0]  wstrb;
  logic                   wlast;
  logic                   wvalid;
  logic                   wready;
  logic [AXI_ID_W-1:0]    bid;
  logic [AXI_RESP_W-1:0]  bresp;
  logic                   bvalid;
  logic                   bready;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [WB_ADR_W-1:0]    wb_adr;
  logic [WB_DAT_W-1:0]    wb_dat_o;
  logic [WB_SEL_W-1:0]    wb_sel;
  logic                   wb_ack;
  logic                   rec_valid;
  logic                   rec_we;
  logic                   rec_first;
  logic [WB_ADR_W-1:0]    rec_adr;
  logic [WB_DAT_W-1:0]    rec_dat;
  logic [WB_SEL_W-1:0]    rec_sel;

  logic [31:0]         rng;
  wb_write_t           exp_q[$];
  int                  rd_idx = 0;
  int                  errors = 0;
  int                  cmp_errors = 0;
  logic [WB_DAT_W-1:0] beat_data [16];
  logic [WB_SEL_W-1:0] beat_strb [16];

  axi_wb_write_bridge dut_i (.*);

  wb_target_model #(.SEED(SEED)) target_i (.wb_dat(wb_dat_o), .*);

  always #20 axi_clk = ~axi_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Beat i of an INCR burst lands 4 bytes further on, a FIXED burst stays put.
  function automatic wb_write_t expected_write(input logic [31:0] base,
      input logic [1:0] burst, input int i, input logic [31:0] data, input logic [3:0] strb);
    wb_write_t w;
    w.adr   = (burst == BURST_INCR) ? base + 32'(4 * i) : base;
    w.dat   = data;
    w.sel   = strb;
    w.first = (i == 0);
    return w;
  endfunction

  function automatic int mismatch(input string name, input logic [31:0] got,
      input logic [31:0] want);
    int bad;
    bad = 0;
    assert (got === want) else begin
      $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, want);
      bad = 1;
    end
    return bad;
  endfunction

  function automatic int total_errors();
    return errors + cmp_errors;
  endfunction

  task automatic report_test(input string name, input int start_errors);
    int n;
    n = total_errors() - start_errors;
    if (n == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d failed checks", name, n);
    end
  endtask

  task automatic send_burst(input logic [1:0] burst, input logic [3:0] len,
      input int bready_delay);
    int          tries;
    int          nbeats;
    logic [31:0] r;
    logic [3:0]  id;
    logic [31:0] addr;
    r      = next_rand();
    id     = r[3:0];
    r      = next_rand();
    // Keep the burst inside one 4 KB page.
    addr   = {r[31:12], 2'b00, r[9:2], 2'b00};
    nbeats = int'(len) + 1;
    for (int i = 0; i < nbeats; i++) begin
      beat_data[i] = next_rand();
      r            = next_rand();
      beat_strb[i] = r[3:0];
      exp_q.push_back(expected_write(addr, burst, i, beat_data[i], beat_strb[i]));
    end

    @(negedge axi_clk);
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    awsize  = SIZE_WORD;
    awburst = burst;
    awvalid = 1'b1;
    tries   = 0;
    while (!awready && tries < TIMEOUT) begin
      @(negedge axi_clk);
      tries++;
    end
    if (!awready) begin
      $display("Timeout: awready stayed low for the burst to %h", addr);
      errors++;
    end
    @(posedge axi_clk);

    for (int i = 0; i < nbeats; i++) begin
      @(negedge axi_clk);
      awvalid = 1'b0;
      wid     = id;
      wdata   = beat_data[i];
      wstrb   = beat_strb[i];
      wlast   = (i == nbeats - 1);
      wvalid  = 1'b1;
      tries   = 0;
      while (!wready && tries < TIMEOUT) begin
        @(negedge axi_clk);
        tries++;
      end
      if (!wready) begin
        $display("Timeout: wready stayed low on beat %0d of the burst to %h", i, addr);
        errors++;
      end
      @(posedge axi_clk);
    end

    @(negedge axi_clk);
    wvalid = 1'b0;
    wlast  = 1'b0;
    tries  = 0;
    while (!bvalid && tries < TIMEOUT) begin
      @(negedge axi_clk);
      tries++;
    end
    if (!bvalid) begin
      $display("Timeout: no B response for the burst to %h", addr);
      errors++;
    end
    errors += mismatch("bresp", 32'(bresp), 32'(RESP_OKAY));
    errors += mismatch("bid", 32'(bid), 32'(id));
    repeat (bready_delay) begin
      @(negedge axi_clk);
      errors += mismatch("bvalid", 32'(bvalid), 32'd1);
    end
    bready = 1'b1;
    @(posedge axi_clk);
    @(negedge axi_clk);
    bready = 1'b0;
    // A second response for the same burst would show up here.
    errors += mismatch("bvalid", 32'(bvalid), 32'd0);
  endtask

  task automatic wait_writes();
    int tries;
    tries = 0;
    while (rd_idx < exp_q.size() && tries < TIMEOUT) begin
      @(negedge axi_clk);
      tries++;
    end
    if (rd_idx < exp_q.size()) begin
      $display("Timeout: %0d expected Wishbone writes never arrived", exp_q.size() - rd_idx);
      errors++;
    end
  endtask

  // Each reported write takes the next expected entry in order.
  always @(negedge axi_clk) begin
    wb_write_t want;
    if (reset_n && rec_valid) begin
      if (rd_idx >= exp_q.size()) begin
        $display("Extra Wishbone write to %h arrived with none expected", rec_adr);
        cmp_errors++;
      end else begin
        want = exp_q[rd_idx];
        rd_idx++;
        cmp_errors += mismatch("wb_adr", rec_adr, want.adr);
        cmp_errors += mismatch("wb_dat_o", rec_dat, want.dat);
        cmp_errors += mismatch("wb_sel", 32'(rec_sel), 32'(want.sel));
        cmp_errors += mismatch("wb_we", 32'(rec_we), 32'd1);
        cmp_errors += mismatch("wb_cyc block start", 32'(rec_first), 32'(want.first));
      end
    end
  end

  initial begin
    int          mark;
    int          tries;
    logic [31:0] r;
    axi_clk = 1'b0;
    reset_n = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awsize  = '0;
    awburst = '0;
    awlock  = '0;
    awcache = '0;
    awprot  = '0;
    awvalid = 1'b0;
    wid     = '0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    rng     = SEED;

    mark = total_errors();
    repeat (5) begin
      @(negedge axi_clk);
      errors += mismatch("bvalid", 32'(bvalid), 32'd0);
      errors += mismatch("wready", 32'(wready), 32'd0);
      errors += mismatch("wb_cyc", 32'(wb_cyc), 32'd0);
      errors += mismatch("wb_stb", 32'(wb_stb), 32'd0);
    end
    reset_n = 1'b1;
    tries   = 0;
    while (!awready && tries < 4) begin
      @(negedge axi_clk);
      tries++;
    end
    if (!awready) begin
      $display("awready did not rise within 4 cycles after reset");
      errors++;
    end
    errors += mismatch("bvalid", 32'(bvalid), 32'd0);
    errors += mismatch("wb_cyc", 32'(wb_cyc), 32'd0);
    report_test("Reset state", mark);

    mark = total_errors();
    send_burst(BURST_INCR, 4'd0, 0);
    wait_writes();
    report_test("Single-beat write", mark);

    mark = total_errors();
    repeat (8) begin
      r = next_rand();
      send_burst(BURST_INCR, r[3:0], 0);
    end
    wait_writes();
    report_test("INCR bursts", mark);

    mark = total_errors();
    repeat (6) begin
      r = next_rand();
      send_burst(BURST_FIXED, r[3:0], 0);
    end
    wait_writes();
    report_test("FIXED bursts", mark);

    mark = total_errors();
    repeat (8) begin
      r = next_rand();
      send_burst(r[4] ? BURST_INCR : BURST_FIXED, r[3:0], int'(r[10:8]));
    end
    wait_writes();
    report_test("B response", mark);

    mark = total_errors();
    repeat (40) begin
      r = next_rand();
      send_burst(r[4] ? BURST_INCR : BURST_FIXED, r[3:0], 0);
    end
    wait_writes();
    // Leave time for a stray write to show up.
    repeat (20) @(negedge axi_clk);
    errors += mismatch("wb_cyc", 32'(wb_cyc), 32'd0);
    report_test("Back-pressure", mark);

    $display("Writes checked: %0d of %0d, errors: %0d", rd_idx, exp_q.size(), total_errors());
    if (total_errors() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/wb_target_model.sv */
// --------------------
// Wishbone target with random wait states. Reports every
// write that it acks.
// --------------------
`default_nettype none

module wb_target_model import bridge_pkg::*; #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic                axi_clk,
  input  logic                reset_n,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [WB_ADR_W-1:0] wb_adr,
  input  logic [WB_DAT_W-1:0] wb_dat,
  input  logic [WB_SEL_W-1:0] wb_sel,
  output logic                wb_ack,
  output logic                rec_valid,
  output logic                rec_we,
  output logic                rec_first,
  output logic [WB_ADR_W-1:0] rec_adr,
  output logic [WB_DAT_W-1:0] rec_dat,
  output logic [WB_SEL_W-1:0] rec_sel
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] rng;
  logic [1:0]  wait_left;
  logic        block_start;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  always_ff @(posedge axi_clk or negedge reset_n) begin
    if (!reset_n) begin
      rng         <= SEED;
      wait_left   <= '0;
      block_start <= 1'b1;
      wb_ack      <= 1'b0;
      rec_valid   <= 1'b0;
      rec_we      <= 1'b0;
      rec_first   <= 1'b0;
      rec_adr     <= '0;
      rec_dat     <= '0;
      rec_sel     <= '0;
    end else begin
      rec_valid <= 1'b0;
      // A low cycle marks the start of a new block.
      if (!wb_cyc) begin
        block_start <= 1'b1;
      end
      if (wb_ack) begin
        wb_ack      <= 1'b0;
        rec_valid   <= 1'b1;
        rec_we      <= wb_we;
        rec_first   <= block_start;
        rec_adr     <= wb_adr;
        rec_dat     <= wb_dat;
        rec_sel     <= wb_sel;
        block_start <= 1'b0;
        rng         <= xorshift(rng);
        wait_left   <= rng[1:0];
      end else if (wb_cyc && wb_stb) begin
        if (wait_left == '0) begin
          wb_ack <= 1'b1;
        end else begin
          wait_left <= wait_left - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/axi_pkg.sv
rtl/bridge_pkg.sv
rtl/queue_if.sv
rtl/sync_fifo.sv
rtl/axi_write_ingress.sv
rtl/wb_write_egress.sv
rtl/axi_wb_write_bridge.sv
testbench/wb_target_model.sv
testbench/tb_bridge.sv
